// File: hw/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Byte offset within a line
`define CACHE_OFFSET_W 4

// Set index bits
`define CACHE_INDEX_W 3

// log2 of the associativity
`define CACHE_WAY_W 2

// Line width in bits, one byte per offset value
`define CACHE_LINE_W (8 * (1 << `CACHE_OFFSET_W))

// Remaining upper address bits
`define CACHE_TAG_W (32 - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`define CACHE_SETS (1 << `CACHE_INDEX_W)

`define CACHE_WAYS (1 << `CACHE_WAY_W)

`endif

// File: hw/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    // Byte address split for the array lookup
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // Same 32 bits, flat or split
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t fields;
    } addr_u;

    typedef struct packed {
        logic                     write;
        addr_u                    addr;
        logic [`CACHE_LINE_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_LINE_W-1:0] rdata;
    } cpu_resp_t;

    // Line-aligned memory request, read or writeback
    typedef struct packed {
        logic                     write;
        logic [31:0]              addr;
        logic [`CACHE_LINE_W-1:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT
    } ctrl_state_e;

endpackage

// File: hw/cache_way.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_way (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CACHE_INDEX_W-1:0] index,
    input  logic [`CACHE_TAG_W-1:0]   tag,
    input  logic                      lookup_en,
    input  logic                      load,
    input  logic                      new_dirty,
    input  logic [`CACHE_LINE_W-1:0]  line_in,
    output logic                      way_valid,
    output logic                      way_dirty,
    output logic [`CACHE_TAG_W-1:0]   way_tag,
    output logic [`CACHE_LINE_W-1:0]  way_line,
    output logic                      way_hit
);

    logic [`CACHE_SETS-1:0]   valid;
    logic [`CACHE_SETS-1:0]   dirty;
    logic [`CACHE_TAG_W-1:0]  tags  [`CACHE_SETS];
    logic [`CACHE_LINE_W-1:0] lines [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (load) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dirty[index] <= new_dirty;
            tags[index]  <= tag;
            lines[index] <= line_in;
        end
    end

    // Read register, also follows a load so it never shows stale contents
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            way_valid <= 1'b0;
        end else if (load) begin
            way_valid <= 1'b1;
        end else if (lookup_en) begin
            way_valid <= valid[index];
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            way_dirty <= new_dirty;
            way_tag   <= tag;
            way_line  <= line_in;
        end else if (lookup_en) begin
            way_dirty <= dirty[index];
            way_tag   <= tags[index];
            way_line  <= lines[index];
        end
    end

    // Compared against the live request tag
    assign way_hit = way_valid && (way_tag == tag);

endmodule

// File: hw/way_arbiter.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module way_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`CACHE_INDEX_W-1:0] index,
    input  logic [`CACHE_WAYS-1:0]    way_hits,
    input  logic [`CACHE_WAYS-1:0]    way_valids,
    input  logic [`CACHE_WAYS-1:0]    way_dirtys,
    input  logic [`CACHE_TAG_W-1:0]   way_tags [`CACHE_WAYS],
    input  logic [`CACHE_LINE_W-1:0]  way_lines [`CACHE_WAYS],
    input  logic                      lru_load,
    output logic [`CACHE_WAYS-1:0]    sel_way,
    output logic                      hit,
    output logic                      victim_dirty,
    output logic [`CACHE_TAG_W-1:0]   sel_tag,
    output logic [`CACHE_LINE_W-1:0]  sel_line
);

    localparam int WAY_W = `CACHE_WAY_W;

    // Tree bits: [0] root, [1] ways 0/1, [2] ways 2/3
    logic [`CACHE_WAYS-2:0] plru [`CACHE_SETS];
    logic [`CACHE_WAYS-2:0] tree;
    logic [`CACHE_WAYS-1:0] invalid_sel;
    logic [`CACHE_WAYS-1:0] lru_sel;
    logic [WAY_W-1:0]       sel_idx;

    assign tree = plru[index];
    assign hit  = |way_hits;

    always_comb begin
        invalid_sel = '0;
        // Descending, so the lowest invalid way wins
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!way_valids[w]) begin
                invalid_sel    = '0;
                invalid_sel[w] = 1'b1;
            end
        end
    end

    always_comb begin
        lru_sel = '0;
        if (tree[0]) begin
            lru_sel[tree[2] ? 3 : 2] = 1'b1;
        end else begin
            lru_sel[tree[1] ? 1 : 0] = 1'b1;
        end
    end

    always_comb begin
        if (hit) begin
            sel_way = way_hits;
        end else if (|invalid_sel) begin
            sel_way = invalid_sel;
        end else begin
            sel_way = lru_sel;
        end
    end

    always_comb begin
        sel_tag  = '0;
        sel_line = '0;
        sel_idx  = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (sel_way[w]) begin
                sel_tag  |= way_tags[w];
                sel_line |= way_lines[w];
                sel_idx  = WAY_W'(w);
            end
        end
    end

    // Only a valid dirty way needs a writeback
    assign victim_dirty = !hit && |(sel_way & way_valids & way_dirtys);

    // Point the path bits away from the way just used
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                plru[s] <= '0;
            end
        end else if (lru_load) begin
            if (sel_idx[1]) begin
                plru[index][0] <= 1'b0;
                plru[index][2] <= !sel_idx[0];
            end else begin
                plru[index][0] <= 1'b1;
                plru[index][1] <= !sel_idx[0];
            end
        end
    end

endmodule

// File: hw/cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    input  logic resp_ready,
    input  logic mem_req_ready,
    input  logic mem_resp_valid,
    input  logic req_write,
    input  logic hit,
    input  logic victim_dirty,
    output logic req_ready,
    output logic resp_valid,
    output logic mem_req_valid,
    output logic mem_req_write,
    output logic lookup_en,
    output logic capture_req,
    output logic load_en,
    output logic wb_load,
    output logic sel_wb_addr,
    output logic new_dirty,
    output logic lru_load
);

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e next_state;

    // Set in the second LOOKUP cycle when way outputs are valid
    logic looked;
    logic decide;
    logic write_q;

    assign capture_req = req_ready && req_valid;
    assign lookup_en   = (state == cache_pkg::LOOKUP) && !looked;
    assign decide      = (state == cache_pkg::LOOKUP) && looked;
    assign lru_load    = decide && hit;
    assign wb_load     = decide && !hit && victim_dirty;
    assign new_dirty   = decide && write_q;
    assign sel_wb_addr = (state == cache_pkg::WRITEBACK);

    // Write hit or fill return
    assign load_en = (decide && hit && write_q)
                   || ((state == cache_pkg::FILL_WAIT) && mem_resp_valid);

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE:      if (capture_req) next_state = cache_pkg::LOOKUP;
            cache_pkg::LOOKUP: begin
                if (looked) begin
                    if (hit) begin
                        next_state = cache_pkg::RESPOND;
                    end else if (victim_dirty) begin
                        next_state = cache_pkg::WRITEBACK;
                    end else begin
                        next_state = cache_pkg::FILL_REQ;
                    end
                end
            end
            cache_pkg::RESPOND:   if (resp_ready) next_state = cache_pkg::IDLE;
            cache_pkg::WRITEBACK: if (mem_req_ready) next_state = cache_pkg::FILL_REQ;
            cache_pkg::FILL_REQ:  if (mem_req_ready) next_state = cache_pkg::FILL_WAIT;
            cache_pkg::FILL_WAIT: if (mem_resp_valid) next_state = cache_pkg::LOOKUP;
            default:              next_state = cache_pkg::IDLE;
        endcase
    end

    // Handshake outputs registered from the next state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= cache_pkg::IDLE;
            looked        <= 1'b0;
            req_ready     <= 1'b0;
            resp_valid    <= 1'b0;
            mem_req_valid <= 1'b0;
            mem_req_write <= 1'b0;
        end else begin
            state         <= next_state;
            looked        <= lookup_en;
            req_ready     <= (next_state == cache_pkg::IDLE);
            resp_valid    <= (next_state == cache_pkg::RESPOND);
            mem_req_valid <= (next_state == cache_pkg::WRITEBACK)
                          || (next_state == cache_pkg::FILL_REQ);
            mem_req_write <= (next_state == cache_pkg::WRITEBACK);
        end
    end

    always_ff @(posedge clk) begin
        if (capture_req) begin
            write_q <= req_write;
        end
    end

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid);

    // RESPOND is entered only from a hit and left only on resp_ready
    a_resp_after_hit: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> ($past(decide && hit) || $past(resp_valid && !resp_ready)));

endmodule

// File: hw/cache_datapath_core.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_datapath_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cache_pkg::cpu_req_t      req,
    input  logic                     capture_req,
    input  logic                     lookup_en,
    input  logic                     load_en,
    input  logic                     wb_load,
    input  logic                     sel_wb_addr,
    input  logic                     new_dirty,
    input  logic                     lru_load,
    input  logic [`CACHE_LINE_W-1:0] mem_rdata,
    output logic                     hit,
    output logic                     victim_dirty,
    output logic [`CACHE_LINE_W-1:0] rdata,
    output logic [31:0]              mem_addr,
    output logic [`CACHE_LINE_W-1:0] mem_wdata
);

    cache_pkg::cpu_req_t req_q;

    logic [`CACHE_TAG_W-1:0]   tag;
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_WAYS-1:0]    way_hits;
    logic [`CACHE_WAYS-1:0]    way_valids;
    logic [`CACHE_WAYS-1:0]    way_dirtys;
    logic [`CACHE_WAYS-1:0]    sel_way;
    logic [`CACHE_WAYS-1:0]    way_load;
    logic [`CACHE_TAG_W-1:0]   way_tags  [`CACHE_WAYS];
    logic [`CACHE_LINE_W-1:0]  way_lines [`CACHE_WAYS];
    logic [`CACHE_TAG_W-1:0]   sel_tag;
    logic [`CACHE_LINE_W-1:0]  sel_line;
    logic [`CACHE_LINE_W-1:0]  line_in;

    // Payload held for the whole operation
    always_ff @(posedge clk) begin
        if (capture_req) begin
            req_q <= req;
        end
    end

    assign tag   = req_q.addr.fields.tag;
    assign index = req_q.addr.fields.index;

    // Victim address on writeback, request line address on fill
    assign mem_addr = sel_wb_addr
                    ? {sel_tag, index, {`CACHE_OFFSET_W{1'b0}}}
                    : {req_q.addr.word[31:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};

    // Hit means a write hit, else the memory return of a fill
    assign line_in  = hit ? req_q.wdata : mem_rdata;
    assign way_load = {`CACHE_WAYS{load_en}} & sel_way;

    for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
        cache_way way_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .index     (index),
            .tag       (tag),
            .lookup_en (lookup_en),
            .load      (way_load[i]),
            .new_dirty (new_dirty),
            .line_in   (line_in),
            .way_valid (way_valids[i]),
            .way_dirty (way_dirtys[i]),
            .way_tag   (way_tags[i]),
            .way_line  (way_lines[i]),
            .way_hit   (way_hits[i])
        );
    end

    way_arbiter way_arbiter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (index),
        .way_hits     (way_hits),
        .way_valids   (way_valids),
        .way_dirtys   (way_dirtys),
        .way_tags     (way_tags),
        .way_lines    (way_lines),
        .lru_load     (lru_load),
        .sel_way      (sel_way),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .sel_tag      (sel_tag),
        .sel_line     (sel_line)
    );

    assign rdata = sel_line;

    always_ff @(posedge clk) begin
        if (wb_load) begin
            mem_wdata <= sel_line;
        end
    end

    a_way_load_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_load));

endmodule

// File: hw/cache_top.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  cache_pkg::cpu_req_t      req,
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output cache_pkg::cpu_resp_t     resp,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output cache_pkg::mem_req_t      mem_req,
    input  logic                     mem_resp_valid,
    input  logic [`CACHE_LINE_W-1:0] mem_rdata
);

    logic hit;
    logic victim_dirty;
    logic mem_req_write;
    logic lookup_en;
    logic capture_req;
    logic load_en;
    logic wb_load;
    logic sel_wb_addr;
    logic new_dirty;
    logic lru_load;
    logic [`CACHE_LINE_W-1:0] rdata;
    logic [31:0]              mem_addr;
    logic [`CACHE_LINE_W-1:0] mem_wdata;

    assign resp.rdata     = rdata;
    assign mem_req.write  = mem_req_write;
    assign mem_req.addr   = mem_addr;
    assign mem_req.wdata  = mem_wdata;

    cache_control cache_control_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .resp_ready     (resp_ready),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .req_write      (req.write),
        .hit            (hit),
        .victim_dirty   (victim_dirty),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .lookup_en      (lookup_en),
        .capture_req    (capture_req),
        .load_en        (load_en),
        .wb_load        (wb_load),
        .sel_wb_addr    (sel_wb_addr),
        .new_dirty      (new_dirty),
        .lru_load       (lru_load)
    );

    cache_datapath_core cache_datapath_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .capture_req  (capture_req),
        .lookup_en    (lookup_en),
        .load_en      (load_en),
        .wb_load      (wb_load),
        .sel_wb_addr  (sel_wb_addr),
        .new_dirty    (new_dirty),
        .lru_load     (lru_load),
        .mem_rdata    (mem_rdata),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .rdata        (rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

// File: testbench/cache_checker.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  logic                 req_ready,
    input  logic                 resp_valid,
    input  logic                 resp_ready,
    input  cache_pkg::cpu_resp_t resp,
    input  logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    input  cache_pkg::mem_req_t  mem_req,
    output logic                 done,
    output int                   error_count
);

    localparam int MAX_OPS = 64;
    localparam int COLS = 7;

    logic [`CACHE_LINE_W-1:0] vec [MAX_OPS*COLS];
    int   op_count;
    int   cur;
    int   test_errs;
    int   tests_ok;
    int   tests_bad;
    logic read_seen;
    logic wb_seen;
    logic reset_done;

    function automatic string test_name(input int n);
        case (n)
            1: return "reset";
            2: return "cold_read_miss";
            3: return "repeat_read_hit";
            4: return "write_hit_read";
            5: return "plru_eviction";
            6: return "random_stalls";
            default: return "unknown";
        endcase
    endfunction

    function automatic int test_of(input int op);
        if (op >= MAX_OPS) begin
            return 0;
        end
        return int'(vec[op*COLS][7:4]);
    endfunction

    task automatic value_error(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        $display("error %s op %0d %s: expected %h actual %h",
                 test_name(test_of(cur)), cur, what, exp, act);
        test_errs++;
        error_count++;
    endtask

    task automatic plain_error(input string msg);
        $display("%s op %0d: %s", test_name(test_of(cur)), cur, msg);
        test_errs++;
        error_count++;
    endtask

    task automatic finish_test(input int t);
        if (test_errs == 0) begin
            $display("test %0d %s: ok", t, test_name(t));
            tests_ok++;
        end else begin
            $display("test %0d %s: fail with %0d errors", t, test_name(t), test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    initial begin
        for (int i = 0; i < MAX_OPS*COLS; i++) begin
            vec[i] = '0;
        end
        $readmemh("testbench/cache_stimulus.hex", vec);
        done = 1'b0;
        error_count = 0;
        op_count = 0;
        cur = 0;
        test_errs = 0;
        tests_ok = 0;
        tests_bad = 0;
        read_seen = 1'b0;
        wb_seen = 1'b0;
        reset_done = 1'b0;
    end

    // Handshake outputs must stay low while reset is held
    always @(negedge clk) begin
        if (!rst_n && !reset_done) begin
            if (req_ready !== 1'b0 || resp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
                $display("reset: a handshake output is not low during reset");
                test_errs++;
                error_count++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && !reset_done) begin
            reset_done = 1'b1;
            finish_test(1);
        end
        if (rst_n) begin
            if (req_valid && req_ready) begin
                cur = op_count;
                op_count++;
                read_seen = 1'b0;
                wb_seen = 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.write) begin
                    wb_seen = 1'b1;
                    if (vec[cur*COLS+5] == '0) begin
                        plain_error("memory write without a dirty victim");
                    end else begin
                        if (mem_req.addr != vec[cur*COLS+5][31:0]) begin
                            value_error("writeback addr", vec[cur*COLS+5], mem_req.addr);
                        end
                        if (mem_req.wdata != vec[cur*COLS+6]) begin
                            value_error("writeback line", vec[cur*COLS+6], mem_req.wdata);
                        end
                    end
                end else begin
                    read_seen = 1'b1;
                    if (mem_req.addr != {vec[cur*COLS+1][31:4], 4'h0}) begin
                        value_error("fill addr", {vec[cur*COLS+1][31:4], 4'h0},
                                    mem_req.addr);
                    end
                end
            end
            if (resp_valid && resp_ready) begin
                if (resp.rdata != vec[cur*COLS+3]) begin
                    value_error("rdata", vec[cur*COLS+3], resp.rdata);
                end
                if (!read_seen != vec[cur*COLS+4][0]) begin
                    value_error("hit", vec[cur*COLS+4][0], !read_seen);
                end
                if (vec[cur*COLS+5] != '0 && !wb_seen) begin
                    plain_error("dirty victim was not written back");
                end
                if (test_of(cur + 1) != test_of(cur)) begin
                    finish_test(test_of(cur));
                end
                if (test_of(cur + 1) == 0) begin
                    $display("summary: %0d tests ok, %0d tests fail, %0d errors",
                             tests_ok, tests_bad, error_count);
                    done = 1'b1;
                end
            end
        end
    end

endmodule

// File: testbench/tb_cache_top.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_cache_top;

    localparam int MAX_OPS = 64;
    localparam int COLS = 7;
    localparam int HALF_PERIOD = 20;
    localparam int CYCLES_PER_OP = 40;

    logic clk;
    logic rst_n;
    logic req_valid;
    logic req_ready;
    logic resp_valid;
    logic resp_ready;
    logic mem_req_valid;
    logic mem_req_ready;
    logic mem_resp_valid;
    logic [`CACHE_LINE_W-1:0] mem_rdata;
    cache_pkg::cpu_req_t  req;
    cache_pkg::cpu_resp_t resp;
    cache_pkg::mem_req_t  mem_req;

    logic checks_done;
    int   error_count;
    int   n_ops;
    logic [31:0] lfsr_state;
    logic [`CACHE_LINE_W-1:0] stim [MAX_OPS*COLS];
    // Lines written back by the cache
    logic [`CACHE_LINE_W-1:0] mem_lines [logic [31:0]];

    cache_top cache_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp           (resp),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_rdata      (mem_rdata)
    );

    cache_checker cache_checker_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .done          (checks_done),
        .error_count   (error_count)
    );

    // Galois form with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[i] = lfsr_state[0];
        end
    endtask

    function automatic logic [`CACHE_LINE_W-1:0] line_at(input logic [31:0] addr);
        if (mem_lines.exists(addr)) begin
            return mem_lines[addr];
        end
        return {4{addr}};
    endfunction

    task automatic issue_op(input int i);
        req_valid = 1'b1;
        req.write = stim[i*COLS][0];
        req.addr.word = stim[i*COLS+1][31:0];
        req.wdata = stim[i*COLS+2];
        do @(posedge clk); while (!req_ready);
        @(negedge clk);
        req_valid = 1'b0;
        do @(posedge clk); while (!(resp_valid && resp_ready));
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_rdata = '0;
        lfsr_state = 32'h38b9_313d;
        for (int i = 0; i < MAX_OPS*COLS; i++) begin
            stim[i] = '0;
        end
        $readmemh("testbench/cache_stimulus.hex", stim);
        n_ops = 0;
        while (n_ops < MAX_OPS && stim[n_ops*COLS] != '0) begin
            n_ops++;
        end
        fork
            begin
                repeat (n_ops * CYCLES_PER_OP + 10) @(posedge clk);
                $display("timeout: cache did not finish %0d operations in time", n_ops);
                $display("Simulation FAILED");
                $finish;
            end
        join_none
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            issue_op(i);
        end
        wait (checks_done);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Consumer drops ready at random
    always @(negedge clk) begin
        logic [31:0] b;
        if (rst_n) begin
            draw_bits(1, b);
            resp_ready = b[0];
        end
    end

    // Memory model with 0 to 3 stall cycles per request
    initial begin
        logic [31:0] stalls;
        cache_pkg::mem_req_t taken;
        wait (rst_n);
        forever begin
            @(negedge clk);
            if (mem_req_valid) begin
                taken = mem_req;
                draw_bits(2, stalls);
                repeat (stalls) @(negedge clk);
                mem_req_ready = 1'b1;
                @(negedge clk);
                mem_req_ready = 1'b0;
                if (taken.write) begin
                    mem_lines[taken.addr] = taken.wdata;
                end else begin
                    mem_resp_valid = 1'b1;
                    mem_rdata = line_at(taken.addr);
                    @(negedge clk);
                    mem_resp_valid = 1'b0;
                end
            end
        end
    end

endmodule

// File: testbench/cache_stimulus.hex
// op addr wdata exp_rdata exp_hit wb_addr wb_line
// op: test number in the upper nibble, write flag in bit 0; wb_addr 0 means no writeback
20 00001010 0 00001010000010100000101000001010 0 0 0
30 00001010 0 00001010000010100000101000001010 1 0 0
30 0000101c 0 00001010000010100000101000001010 1 0 0
41 00001010 11111111222222223333333344444444 11111111222222223333333344444444 1 0 0
40 00001010 0 11111111222222223333333344444444 1 0 0
// Set 2, fill all four ways then evict the dirty way 0
51 00002020 aaaa0000bbbb1111cccc2222dddd3333 aaaa0000bbbb1111cccc2222dddd3333 0 0 0
50 000020a0 0 000020a0000020a0000020a0000020a0 0 0 0
50 00002120 0 00002120000021200000212000002120 0 0 0
50 000021a0 0 000021a0000021a0000021a0000021a0 0 0 0
50 00002220 0 00002220000022200000222000002220 0 00002020 aaaa0000bbbb1111cccc2222dddd3333
50 00002020 0 aaaa0000bbbb1111cccc2222dddd3333 0 0 0
60 00003030 0 00003030000030300000303000003030 0 0 0
61 00003030 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210 1 0 0
60 00001010 0 11111111222222223333333344444444 1 0 0
60 000030b0 0 000030b0000030b0000030b0000030b0 0 0 0
61 000030b0 cafe0001cafe0002cafe0003cafe0004 cafe0001cafe0002cafe0003cafe0004 1 0 0
60 00003030 0 0123456789abcdeffedcba9876543210 1 0 0
60 000000f0 0 000000f0000000f0000000f0000000f0 0 0 0
60 00002220 0 00002220000022200000222000002220 1 0 0

// File: project.f
+incdir+hw
hw/cache_pkg.sv
hw/cache_way.sv
hw/way_arbiter.sv
hw/cache_control.sv
hw/cache_datapath_core.sv
hw/cache_top.sv
testbench/cache_checker.sv
testbench/tb_cache_top.sv
